//--- hdl/dmacBusPkg.sv
// Wishbone bus types

package dmacBusPkg;

    // One classic cycle request, held stable by the master until ack
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wbReq_t;

    // Slave answer, dat valid only with ack
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRsp_t;

endpackage

//--- hdl/dmacRegPkg.sv
// DMA controller register map

package dmacRegPkg;

    // Word offsets at slave address bits 5:2
    localparam logic [3:0] regCtrl   = 4'd0;
    localparam logic [3:0] regAddr   = 4'd1;
    localparam logic [3:0] regCount  = 4'd2;
    localparam logic [3:0] regStatus = 4'd3;

    localparam int scsiWindowBit = 6;  // Set selects the chip register window

    localparam int fifoWords   = 4;    // Depth in 32-bit words
    localparam int fifoPtrBits = $clog2(fifoWords);

    // dir 0 is chip to memory, dir 1 is memory to chip
    typedef struct packed {
        logic        dmaEn;
        logic        dir;
        logic        intEn;
        logic [31:0] baseAddr;
        logic [28:0] wordCount;
    } dmaCtrl_t;

endpackage

//--- hdl/dmacRegisters.sv
// DMA control and status registers
`timescale 1ns/1ns

module dmacRegisters (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  dmacBusPkg::wbReq_t   req_i,
    input  logic                 sel_i,
    output dmacBusPkg::wbRsp_t   rsp_o,
    input  logic                 dmaDone_i,
    input  logic                 dmaBusy_i,
    output dmacRegPkg::dmaCtrl_t ctrl_o,
    output logic                 intN_o
);
    import dmacRegPkg::*;

    dmaCtrl_t    ctrl;
    logic        doneFlag;
    logic        ackReg;
    logic [31:0] rdDat;
    logic        access;
    logic [3:0]  regSel;

    // Ack gating keeps a held strobe from being taken twice
    assign access = req_i.cyc & req_i.stb & sel_i & ~ackReg;
    assign regSel = req_i.adr[5:2];

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            ackReg   <= 1'b0;
            doneFlag <= 1'b0;
            ctrl     <= '0;
        end else begin
            ackReg <= access;
            if (dmaDone_i) begin
                doneFlag   <= 1'b1;
                ctrl.dmaEn <= 1'b0;  // Transfer finished, stop the engine
            end
            if (access && req_i.we) begin
                case (regSel)
                    regCtrl: begin
                        ctrl.dmaEn <= req_i.dat[0];
                        ctrl.dir   <= req_i.dat[1];
                        ctrl.intEn <= req_i.dat[2];
                    end
                    regAddr:   ctrl.baseAddr  <= req_i.dat;
                    regCount:  ctrl.wordCount <= req_i.dat[28:0];
                    regStatus: begin
                        if (req_i.dat[1]) begin
                            doneFlag <= 1'b0;  // Write 1 to clear
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data sampled in the same edge that raises ack
    always_ff @(posedge QnCPUCLK) begin
        if (access) begin
            case (regSel)
                regCtrl:   rdDat <= {29'd0, ctrl.intEn, ctrl.dir, ctrl.dmaEn};
                regAddr:   rdDat <= ctrl.baseAddr;
                regCount:  rdDat <= {3'd0, ctrl.wordCount};
                regStatus: rdDat <= {30'd0, doneFlag, dmaBusy_i};
                default:   rdDat <= '0;
            endcase
        end
    end

    assign rsp_o.ack = ackReg;
    assign rsp_o.dat = rdDat;
    assign ctrl_o    = ctrl;
    assign intN_o    = ~(doneFlag & ctrl.intEn);  // Completion interrupt

endmodule

//--- hdl/byteFifo.sv
// Byte packing word FIFO
`timescale 1ns/1ns

module byteFifo (
    input  logic        QnCPUCLK,
    input  logic        rstN_i,
    input  logic        wordPush_i,
    input  logic [31:0] wordIn_i,
    input  logic        wordPop_i,
    output logic [31:0] wordOut_o,
    input  logic        bytePush_i,
    input  logic [7:0]  byteIn_i,
    input  logic        bytePop_i,
    output logic [7:0]  byteOut_o,
    output logic        full_o,
    output logic        empty_o,
    input  logic        dmaStart_i
);
    import dmacRegPkg::*;

    logic [31:0]            mem [fifoWords];
    logic [fifoPtrBits:0]   wrPtr;  // Extra bit tells full from empty
    logic [fifoPtrBits:0]   rdPtr;
    logic [fifoPtrBits-1:0] wrIdx;
    logic [fifoPtrBits-1:0] rdIdx;
    logic [1:0]             byteOff;

    assign wrIdx = wrPtr[fifoPtrBits-1:0];
    assign rdIdx = rdPtr[fifoPtrBits-1:0];

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            byteOff <= '0;
        end else if (dmaStart_i) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            byteOff <= '0;
        end else begin
            if (wordPush_i) wrPtr <= wrPtr + 1'b1;
            if (wordPop_i)  rdPtr <= rdPtr + 1'b1;
            // Offset wrap moves the word pointer of the byte side
            if (bytePush_i || bytePop_i) begin
                byteOff <= byteOff + 2'd1;
                if (byteOff == 2'd3) begin
                    if (bytePush_i) wrPtr <= wrPtr + 1'b1;
                    else            rdPtr <= rdPtr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge QnCPUCLK) begin
        if (wordPush_i) begin
            mem[wrIdx] <= wordIn_i;
        end else if (bytePush_i) begin
            mem[wrIdx][{byteOff, 3'b000} +: 8] <= byteIn_i;  // Offset 0 in bits 7:0
        end
    end

    assign wordOut_o = mem[rdIdx];
    assign byteOut_o = mem[rdIdx][{byteOff, 3'b000} +: 8];
    assign empty_o   = (wrPtr == rdPtr);
    assign full_o    = (wrIdx == rdIdx) && (wrPtr[fifoPtrBits] != rdPtr[fifoPtrBits]);

endmodule

//--- hdl/scsiPortSm.sv
// SCSI chip port sequencer
`timescale 1ns/1ns

module scsiPortSm (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  dmacBusPkg::wbReq_t   req_i,
    input  logic                 sel_i,
    output dmacBusPkg::wbRsp_t   rsp_o,
    input  dmacRegPkg::dmaCtrl_t ctrl_i,
    input  logic                 fifoFull_i,
    input  logic                 fifoEmpty_i,
    output logic                 bytePush_o,
    output logic [7:0]           byteIn_o,
    output logic                 bytePop_o,
    input  logic [7:0]           byteOut_i,
    input  logic                 dreqN_i,
    output logic                 dackN_o,
    output logic                 iorN_o,
    output logic                 iowN_o,
    output logic                 cssN_o,
    output logic [2:0]           scsiAdr_o,
    input  logic [7:0]           pdData_i,
    output logic [7:0]           pdData_o,
    output logic                 pdOe_o
);
    typedef enum logic [2:0] {
        sIdle,
        sCpuSetup,
        sCpuStrobe,
        sCpuRecov,
        sCpuAck,
        sDmaStrobe,
        sDmaRecov
    } state_t;

    state_t     state;
    logic       strobeCnt;  // High in the second strobe cycle
    logic       isWrite;
    logic [2:0] adrReg;
    logic [7:0] outByte;
    logic [7:0] rdByte;
    logic       cpuStart;
    logic       dmaRoom;
    logic       dmaStart;
    logic       strobeOn;

    // CPU wins only here, so it slips in between byte cycles
    assign cpuStart = (state == sIdle) && req_i.cyc && req_i.stb && sel_i;
    assign dmaRoom  = ctrl_i.dir ? !fifoEmpty_i : !fifoFull_i;
    assign dmaStart = (state == sIdle) && !cpuStart && !dreqN_i && ctrl_i.dmaEn && dmaRoom;

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state     <= sIdle;
            strobeCnt <= 1'b0;
            isWrite   <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    strobeCnt <= 1'b0;
                    if (cpuStart) begin
                        state   <= sCpuSetup;
                        isWrite <= req_i.we;
                    end else if (dmaStart) begin
                        state   <= sDmaStrobe;
                        isWrite <= ctrl_i.dir;
                    end
                end
                sCpuSetup: state <= sCpuStrobe;
                sCpuStrobe: begin
                    strobeCnt <= ~strobeCnt;
                    if (strobeCnt) state <= sCpuRecov;
                end
                sCpuRecov: state <= sCpuAck;
                sCpuAck:   state <= sIdle;
                sDmaStrobe: begin
                    strobeCnt <= ~strobeCnt;
                    if (strobeCnt) state <= sDmaRecov;
                end
                sDmaRecov: state <= sIdle;
                default:   state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge QnCPUCLK) begin
        if (cpuStart) begin
            adrReg  <= req_i.adr[4:2];
            outByte <= req_i.dat[7:0];
        end else if (dmaStart && ctrl_i.dir) begin
            outByte <= byteOut_i;  // Byte popped as the cycle starts
        end
        if (state == sCpuStrobe && strobeCnt && !isWrite) begin
            rdByte <= pdData_i;    // Chip data settled by the last strobe cycle
        end
    end

    assign strobeOn = (state == sCpuStrobe) || (state == sDmaStrobe);

    assign iorN_o    = ~(strobeOn & ~isWrite);
    assign iowN_o    = ~(strobeOn & isWrite);
    assign cssN_o    = ~((state == sCpuSetup) || (state == sCpuStrobe));
    assign dackN_o   = ~(state == sDmaStrobe);
    assign pdOe_o    = isWrite && ((state == sCpuSetup) || strobeOn);
    assign pdData_o  = outByte;
    assign scsiAdr_o = adrReg;

    assign bytePop_o  = dmaStart & ctrl_i.dir;
    assign bytePush_o = (state == sDmaStrobe) && strobeCnt && !isWrite;
    assign byteIn_o   = pdData_i;

    assign rsp_o.ack = (state == sCpuAck);
    assign rsp_o.dat = {24'd0, rdByte};

endmodule

//--- hdl/memBusMaster.sv
// Wishbone memory master for DMA words
`timescale 1ns/1ns

module memBusMaster (
    input  logic                 QnCPUCLK,
    input  logic                 rstN_i,
    input  dmacRegPkg::dmaCtrl_t ctrl_i,
    output dmacBusPkg::wbReq_t   req_o,
    input  dmacBusPkg::wbRsp_t   rsp_i,
    input  logic                 fifoFull_i,
    input  logic                 fifoEmpty_i,
    output logic                 wordPush_o,
    output logic [31:0]          wordIn_o,
    output logic                 wordPop_o,
    input  logic [31:0]          wordOut_i,
    output logic                 dmaStart_o,
    output logic                 busy_o,
    output logic                 done_o
);
    typedef enum logic [1:0] {
        sIdle,
        sRun,
        sCycle
    } state_t;

    state_t      state;
    logic        enDly;
    logic [28:0] wordsLeft;
    logic [31:0] adrReg;
    logic [31:0] datReg;
    logic        weReg;
    logic        start;
    logic        finish;
    logic        issueWr;
    logic        issueRd;
    logic        wordAck;

    assign start   = ctrl_i.dmaEn & ~enDly;  // Rising edge of dmaEn
    assign finish  = (state == sRun) && (wordsLeft == '0) && fifoEmpty_i;
    assign issueWr = (state == sRun) && (wordsLeft != '0) && ctrl_i.dmaEn
                     && !ctrl_i.dir && !fifoEmpty_i;
    assign issueRd = (state == sRun) && (wordsLeft != '0) && ctrl_i.dmaEn
                     && ctrl_i.dir && !fifoFull_i;
    assign wordAck = (state == sCycle) && rsp_i.ack;

    always_ff @(posedge QnCPUCLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state     <= sIdle;
            enDly     <= 1'b0;
            wordsLeft <= '0;
        end else begin
            enDly <= ctrl_i.dmaEn;
            case (state)
                sIdle: begin
                    if (start) begin
                        state     <= sRun;
                        wordsLeft <= ctrl_i.wordCount;
                    end
                end
                sRun: begin
                    if (finish || !ctrl_i.dmaEn) begin
                        state <= sIdle;  // Done, or stopped by the CPU
                    end else if (issueWr || issueRd) begin
                        state <= sCycle;
                    end
                end
                sCycle: begin
                    if (rsp_i.ack) begin
                        state     <= sRun;
                        wordsLeft <= wordsLeft - 29'd1;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Address, data and direction held for the whole bus cycle
    always_ff @(posedge QnCPUCLK) begin
        if (state == sIdle && start) begin
            adrReg <= ctrl_i.baseAddr;
        end else if (wordAck) begin
            adrReg <= adrReg + 32'd4;
        end
        if (issueWr || issueRd) begin
            weReg  <= issueWr;
            datReg <= wordOut_i;
        end
    end

    assign req_o.cyc = (state == sCycle);
    assign req_o.stb = (state == sCycle);
    assign req_o.we  = weReg;
    assign req_o.adr = adrReg;
    assign req_o.dat = datReg;
    assign req_o.sel = 4'hf;

    assign wordPush_o = wordAck & ~weReg;  // Read word enters FIFO on ack
    assign wordIn_o   = rsp_i.dat;
    assign wordPop_o  = wordAck & weReg;

    assign dmaStart_o = (state == sIdle) && start;
    assign busy_o     = (state != sIdle);
    assign done_o     = finish;

endmodule

//--- hdl/sdmacTop.sv
// SCSI DMA controller top level
`timescale 1ns/1ns

module sdmacTop (
    input  logic               QnCPUCLK,
    input  logic               rstN_i,
    input  dmacBusPkg::wbReq_t cpuReq_i,
    output dmacBusPkg::wbRsp_t cpuRsp_o,
    output dmacBusPkg::wbReq_t memReq_o,
    input  dmacBusPkg::wbRsp_t memRsp_i,
    input  logic               dreqN_i,
    output logic               dackN_o,
    output logic               iorN_o,
    output logic               iowN_o,
    output logic               cssN_o,
    output logic [2:0]         scsiAdr_o,
    input  logic [7:0]         pdData_i,
    output logic [7:0]         pdData_o,
    output logic               pdOe_o,
    output logic               intN_o
);
    import dmacBusPkg::*;
    import dmacRegPkg::*;

    wbRsp_t      regRsp;
    wbRsp_t      scsiRsp;
    dmaCtrl_t    dmaCtrl;
    logic        scsiSel;
    logic        regSel;
    logic        dmaDone;
    logic        dmaBusy;
    logic        dmaStart;
    logic        fifoFull;
    logic        fifoEmpty;
    logic        wordPush;
    logic [31:0] wordIn;
    logic        wordPop;
    logic [31:0] wordOut;
    logic        bytePush;
    logic [7:0]  byteIn;
    logic        bytePop;
    logic [7:0]  byteOut;

    // Upper half of the slave window belongs to the chip
    assign scsiSel = cpuReq_i.adr[scsiWindowBit];
    assign regSel  = ~scsiSel;

    assign cpuRsp_o.ack = regRsp.ack | scsiRsp.ack;
    assign cpuRsp_o.dat = scsiRsp.ack ? scsiRsp.dat : regRsp.dat;

    dmacRegisters u_regs (
        .QnCPUCLK  (QnCPUCLK ),
        .rstN_i    (rstN_i   ),
        .req_i     (cpuReq_i ),
        .sel_i     (regSel   ),
        .rsp_o     (regRsp   ),
        .dmaDone_i (dmaDone  ),
        .dmaBusy_i (dmaBusy  ),
        .ctrl_o    (dmaCtrl  ),
        .intN_o    (intN_o   )
    );

    byteFifo u_fifo (
        .QnCPUCLK   (QnCPUCLK  ),
        .rstN_i     (rstN_i    ),
        .wordPush_i (wordPush  ),
        .wordIn_i   (wordIn    ),
        .wordPop_i  (wordPop   ),
        .wordOut_o  (wordOut   ),
        .bytePush_i (bytePush  ),
        .byteIn_i   (byteIn    ),
        .bytePop_i  (bytePop   ),
        .byteOut_o  (byteOut   ),
        .full_o     (fifoFull  ),
        .empty_o    (fifoEmpty ),
        .dmaStart_i (dmaStart  )
    );

    scsiPortSm u_scsiSm (
        .QnCPUCLK    (QnCPUCLK  ),
        .rstN_i      (rstN_i    ),
        .req_i       (cpuReq_i  ),
        .sel_i       (scsiSel   ),
        .rsp_o       (scsiRsp   ),
        .ctrl_i      (dmaCtrl   ),
        .fifoFull_i  (fifoFull  ),
        .fifoEmpty_i (fifoEmpty ),
        .bytePush_o  (bytePush  ),
        .byteIn_o    (byteIn    ),
        .bytePop_o   (bytePop   ),
        .byteOut_i   (byteOut   ),
        .dreqN_i     (dreqN_i   ),
        .dackN_o     (dackN_o   ),
        .iorN_o      (iorN_o    ),
        .iowN_o      (iowN_o    ),
        .cssN_o      (cssN_o    ),
        .scsiAdr_o   (scsiAdr_o ),
        .pdData_i    (pdData_i  ),
        .pdData_o    (pdData_o  ),
        .pdOe_o      (pdOe_o    )
    );

    memBusMaster u_memMaster (
        .QnCPUCLK    (QnCPUCLK  ),
        .rstN_i      (rstN_i    ),
        .ctrl_i      (dmaCtrl   ),
        .req_o       (memReq_o  ),
        .rsp_i       (memRsp_i  ),
        .fifoFull_i  (fifoFull  ),
        .fifoEmpty_i (fifoEmpty ),
        .wordPush_o  (wordPush  ),
        .wordIn_o    (wordIn    ),
        .wordPop_o   (wordPop   ),
        .wordOut_i   (wordOut   ),
        .dmaStart_o  (dmaStart  ),
        .busy_o      (dmaBusy   ),
        .done_o      (dmaDone   )
    );

endmodule

//--- tb/sdmacChecks_sva.sv
// DMA controller protocol checks
`timescale 1ns/1ns

module sdmacChecks_sva (
    input logic               QnCPUCLK,
    input logic               rstN_i,
    input dmacBusPkg::wbReq_t memReq_i,
    input dmacBusPkg::wbRsp_t memRsp_i,
    input logic               dreqN_i,
    input logic               dackN_i,
    input logic               iorN_i,
    input logic               iowN_i,
    input logic               intN_i,
    input logic               doneFlag_i
);
    int failCount = 0;  // Read by the testbench for its closing line

    // Chip strobes are mutually exclusive
    strobeExclusive: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !(!iorN_i && !iowN_i))
    else begin
        $error("iorN_o and iowN_o low in the same cycle");
        failCount++;
    end

    dackAfterDreq: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        $fell(dackN_i) |-> !$past(dreqN_i))
    else begin
        $error("dackN_o fell while dreqN_i was high");
        failCount++;
    end

    // Request held inside cyc until the slave answers
    reqHeldToAck: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        memReq_i.stb && !memRsp_i.ack |=> memReq_i.stb && memReq_i.cyc
            && $stable(memReq_i.adr) && $stable(memReq_i.dat) && $stable(memReq_i.we))
    else begin
        $error("memory request changed before ack");
        failCount++;
    end

    // Interrupt only once the transfer is over and the bus is quiet
    intNeedsDone: assert property (@(posedge QnCPUCLK) disable iff (!rstN_i)
        !intN_i |-> doneFlag_i && !memReq_i.cyc)
    else begin
        $error("intN_o low without the done flag or during a memory cycle");
        failCount++;
    end

endmodule

bind sdmacTop sdmacChecks_sva u_checks (
    .QnCPUCLK   (QnCPUCLK        ),
    .rstN_i     (rstN_i          ),
    .memReq_i   (memReq_o        ),
    .memRsp_i   (memRsp_i        ),
    .dreqN_i    (dreqN_i         ),
    .dackN_i    (dackN_o         ),
    .iorN_i     (iorN_o          ),
    .iowN_i     (iowN_o          ),
    .intN_i     (intN_o          ),
    .doneFlag_i (u_regs.doneFlag )
);

//--- tb/sdmacTb.sv
// SCSI DMA controller testbench
`timescale 1ns/1ns

module sdmacTb;
    import dmacBusPkg::*;
    import dmacRegPkg::*;

    localparam int          clkPeriod     = 4;
    localparam logic [31:0] seed          = 32'h1d5d_f320;
    localparam int          totalWords    = 6 + 5 + 9 + 12;
    // Four byte cycles with dreq gaps and chip reads, plus one memory word
    localparam int          cyclesPerWord = 40;
    localparam int          timeoutNs     = 20 * totalWords * cyclesPerWord * clkPeriod;

    logic        QnCPUCLK;
    logic        rstN_i;
    wbReq_t      cpuReq_i;
    wbRsp_t      cpuRsp_o;
    wbReq_t      memReq_o;
    wbRsp_t      memRsp_i = '0;
    logic        dreqN_i  = 1'b1;
    logic        dackN_o;
    logic        iorN_o;
    logic        iowN_o;
    logic        cssN_o;
    logic [2:0]  scsiAdr_o;
    logic [7:0]  pdData_i = '0;
    logic [7:0]  pdData_o;
    logic        pdOe_o;
    logic        intN_o;

    logic [31:0] memory [64];
    int          memWait;
    logic [7:0]  deviceRegs [8];
    logic [7:0]  srcBytes [$];
    logic [7:0]  sinkBytes [$];
    int          dmaTotal   = 0;  // Bytes the device still offers
    int          dmaStarted = 0;
    logic        dmaPhase   = 1'b0;
    logic [2:0]  lastWrAdr;
    logic        lastWrOe;
    int          checkErrors = 0;

    sdmacTop u_dut (
        .QnCPUCLK  (QnCPUCLK ),
        .rstN_i    (rstN_i   ),
        .cpuReq_i  (cpuReq_i ),
        .cpuRsp_o  (cpuRsp_o ),
        .memReq_o  (memReq_o ),
        .memRsp_i  (memRsp_i ),
        .dreqN_i   (dreqN_i  ),
        .dackN_o   (dackN_o  ),
        .iorN_o    (iorN_o   ),
        .iowN_o    (iowN_o   ),
        .cssN_o    (cssN_o   ),
        .scsiAdr_o (scsiAdr_o),
        .pdData_i  (pdData_i ),
        .pdData_o  (pdData_o ),
        .pdOe_o    (pdOe_o   ),
        .intN_o    (intN_o   )
    );

    initial begin : clockGen
        QnCPUCLK = 1'b0;
        forever #(clkPeriod / 2) QnCPUCLK = ~QnCPUCLK;
    end

    initial begin : watchdog
        #(timeoutNs);
        $display("timeout: the tests did not finish within %0d ns", timeoutNs);
        $display("TEST FAIL");
        $finish;
    end

    // Memory slave with 0 to 3 wait cycles
    always @(negedge QnCPUCLK) begin : memoryModel
        if (memRsp_i.ack) begin
            memRsp_i.ack <= 1'b0;
        end else if (memReq_o.cyc && memReq_o.stb) begin
            if (memWait == 0) begin
                expectValue("memory byte selects", {28'd0, memReq_o.sel}, 32'hf);
                if (memReq_o.we) begin
                    memory[memReq_o.adr[7:2]] = memReq_o.dat;
                end
                memRsp_i.ack <= 1'b1;
                memRsp_i.dat <= memory[memReq_o.adr[7:2]];
                memWait = int'($urandom % 4);
            end else begin
                memWait--;
            end
        end
    end

    // SCSI chip with register file, byte source and byte sink
    always @(negedge QnCPUCLK) begin : scsiDevice
        if (!dackN_o) begin
            if (!dmaPhase) begin
                if (!iorN_o) begin
                    pdData_i <= srcBytes[dmaStarted];
                end
                dmaStarted++;
            end else if (!iowN_o) begin
                sinkBytes.push_back(pdData_o);  // Second strobe cycle
            end
            dmaPhase = ~dmaPhase;
        end else if (!cssN_o) begin
            if (!iowN_o) begin
                deviceRegs[scsiAdr_o] = pdData_o;
                lastWrAdr = scsiAdr_o;
                lastWrOe  = pdOe_o;
            end
            pdData_i <= deviceRegs[scsiAdr_o];
        end
        dreqN_i <= (dmaStarted >= dmaTotal) || ($urandom % 3 == 0);  // Random gaps
    end

    function automatic logic [31:0] regAdr(input logic [3:0] r);
        return {26'd0, r, 2'b00};
    endfunction

    function automatic logic [31:0] chipAdr(input logic [2:0] r);
        return {25'd0, 1'b1, 1'b0, r, 2'b00};  // Bit 6 opens the chip window
    endfunction

    task automatic expectValue(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            checkErrors++;
        end
    endtask

    task automatic cpuCycle(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
        @(negedge QnCPUCLK);
        cpuReq_i.cyc <= 1'b1;
        cpuReq_i.stb <= 1'b1;
        cpuReq_i.we  <= we;
        cpuReq_i.adr <= adr;
        cpuReq_i.dat <= wdat;
        cpuReq_i.sel <= 4'hf;
        do @(negedge QnCPUCLK); while (!cpuRsp_o.ack);
        rdat = cpuRsp_o.dat;
        cpuReq_i.cyc <= 1'b0;
        cpuReq_i.stb <= 1'b0;
        cpuReq_i.we  <= 1'b0;
    endtask

    task automatic busWrite(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        cpuCycle(1'b1, adr, wdat, unused);
    endtask

    task automatic busRead(input logic [31:0] adr, output logic [31:0] rdat);
        cpuCycle(1'b0, adr, 32'd0, rdat);
    endtask

    // Poll status, with a chip register read now and then
    task automatic waitDone(output logic [31:0] status);
        logic [31:0] chipByte;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1]) begin
            busRead(regAdr(regStatus), status);
            if (polls % 4 == 3) begin
                busRead(chipAdr(3'd7), chipByte);
                expectValue("chip register 7 during DMA", chipByte, {24'd0, deviceRegs[7]});
            end
            polls++;
        end
    endtask

    task automatic runTransfer(input logic dir, input logic [31:0] base, input int words,
                               input logic intEn);
        logic [31:0] rd;
        logic [31:0] expWord;
        int          first;
        int          k;
        int          j;
        first = int'(base[7:2]);
        srcBytes.delete();
        sinkBytes.delete();
        for (k = 0; k < 4 * words; k++) begin
            srcBytes.push_back(8'($urandom));
        end
        if (dir) begin
            for (k = 0; k < words; k++) begin
                memory[first + k] = $urandom;
            end
        end
        dmaStarted = 0;
        dmaTotal   = 4 * words;
        busWrite(regAdr(regAddr), base);
        busWrite(regAdr(regCount), 32'(words));
        busWrite(regAdr(regCtrl), {29'd0, intEn, dir, 1'b1});
        waitDone(rd);
        expectValue("status at done", rd, 32'd2);
        expectValue("intN_o at done", {31'd0, intN_o}, {31'd0, !intEn});
        busRead(regAdr(regCtrl), rd);
        expectValue("ctrl after done", rd, {29'd0, intEn, dir, 1'b0});
        if (dir) begin
            expectValue("bytes received by the sink", sinkBytes.size(), 4 * words);
            if (sinkBytes.size() == 4 * words) begin
                for (k = 0; k < words; k++) begin
                    for (j = 0; j < 4; j++) begin
                        expectValue($sformatf("sink byte %0d", 4 * k + j),
                                    {24'd0, sinkBytes[4 * k + j]},
                                    {24'd0, memory[first + k][8 * j +: 8]});
                    end
                end
            end
        end else begin
            for (k = 0; k < words; k++) begin
                expWord = {srcBytes[4 * k + 3], srcBytes[4 * k + 2],
                           srcBytes[4 * k + 1], srcBytes[4 * k]};
                expectValue($sformatf("memory word %0d", first + k), memory[first + k], expWord);
            end
        end
        busWrite(regAdr(regStatus), 32'd2);  // Clear done
        busRead(regAdr(regStatus), rd);
        expectValue("status after clear", rd, 32'd0);
        expectValue("intN_o after clear", {31'd0, intN_o}, 32'd1);
    endtask

    initial begin : stimulus
        logic [31:0] rd;
        int          i;
        void'($urandom(seed));
        rstN_i   = 1'b0;
        cpuReq_i = '0;
        memWait  = 0;
        for (i = 0; i < 64; i++) begin
            memory[i] = (32'(i) * 32'h0104_1041) ^ 32'h5a5a_a5a5;
        end
        for (i = 0; i < 8; i++) begin
            deviceRegs[i] = 8'hc0 | 8'(i);
        end
        repeat (16) @(posedge QnCPUCLK);
        @(negedge QnCPUCLK);
        rstN_i = 1'b1;

        // Idle levels and register read back
        expectValue("outputs after reset",
                    {23'd0, iorN_o, iowN_o, dackN_o, cssN_o, intN_o, pdOe_o,
                     memReq_o.cyc, memReq_o.stb, cpuRsp_o.ack}, 32'h1f0);
        busRead(regAdr(regStatus), rd);
        expectValue("status after reset", rd, 32'd0);
        busWrite(regAdr(regCtrl), 32'h6);
        busRead(regAdr(regCtrl), rd);
        expectValue("ctrl read back", rd, 32'h6);
        busWrite(regAdr(regCtrl), 32'h0);
        busWrite(regAdr(regAddr), 32'hdead_beec);
        busRead(regAdr(regAddr), rd);
        expectValue("address read back", rd, 32'hdead_beec);
        busWrite(regAdr(regCount), 32'h0123_4567);
        busRead(regAdr(regCount), rd);
        expectValue("count read back", rd, 32'h0123_4567);

        // Chip register window
        busWrite(chipAdr(3'd2), 32'h0000_00a7);
        expectValue("chip register 2 after write", {24'd0, deviceRegs[2]}, 32'h0000_00a7);
        expectValue("chip address on write", {29'd0, lastWrAdr}, 32'd2);
        expectValue("pdOe_o during write strobe", {31'd0, lastWrOe}, 32'd1);
        busRead(chipAdr(3'd5), rd);
        expectValue("chip register 5 read", rd, 32'h0000_00c5);
        busRead(chipAdr(3'd2), rd);
        expectValue("chip register 2 read", rd, 32'h0000_00a7);

        // Transfers under random memory waits and dreq gaps
        runTransfer(1'b0, 32'h0000_0000, 6, 1'b1);
        runTransfer(1'b1, 32'h0000_0040, 5, 1'b0);
        runTransfer(1'b0, 32'h0000_0080, 9, 1'b0);
        runTransfer(1'b1, 32'h0000_00c0, 12, 1'b1);

        $display("errors: %0d value checks, %0d assertion failures",
                 checkErrors, u_dut.u_checks.failCount);
        if (checkErrors == 0 && u_dut.u_checks.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
hdl/dmacBusPkg.sv
hdl/dmacRegPkg.sv
hdl/dmacRegisters.sv
hdl/byteFifo.sv
hdl/scsiPortSm.sv
hdl/memBusMaster.sv
hdl/sdmacTop.sv
tb/sdmacChecks_sva.sv
tb/sdmacTb.sv

//--- Makefile
SIM       ?= verilator
FLIST     ?= flist.f
TOP       ?= sdmacTb
OBJDIR    ?= obj_dir
SIMFLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
